//--- verilog/uart_boot_pkg.sv
// Types, register map, token bytes and timing constants for the UART boot loader
package uart_boot_pkg;

    // ------------------------------
    // Data types
    // ------------------------------
    typedef logic [7:0]  byte_t;                 // One serial byte
    typedef logic [31:0] word_t;                 // Memory word and byte address

    localparam int FIFO_AW = 4;                  // 16 bytes per direction
    typedef logic [FIFO_AW:0] count_t;           // Occupancy 0 to 16

    // ------------------------------
    // Timing
    // ------------------------------
    localparam int CLKS_PER_BIT        = 8;      // Bit rate as clocks per bit
    localparam int BOOT_TIMEOUT_CYCLES = 6000;   // Forced core release after reset
    localparam int SIZE_W              = 18;     // Word count field, three bytes on the wire

    // ------------------------------
    // Slave register map
    // ------------------------------
    localparam logic [2:0] REG_BUFFER   = 3'd0;  // Write pushes TX, read pops RX
    localparam logic [2:0] REG_TX_COUNT = 3'd1;
    localparam logic [2:0] REG_RX_COUNT = 3'd2;

    // Boot protocol tokens, ASCII
    localparam byte_t TOK_U = 8'h55;
    localparam byte_t TOK_S = 8'h53;
    localparam byte_t TOK_B = 8'h42;
    localparam byte_t TOK_A = 8'h41;
    localparam byte_t TOK_C = 8'h43;
    localparam byte_t TOK_K = 8'h4B;

endpackage

//--- verilog/byte_fifo.sv
// Synchronous byte FIFO, circular buffer with occupancy count
module byte_fifo (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push_i,
    input  uart_boot_pkg::byte_t  data_i,
    input  logic                  pop_i,
    output uart_boot_pkg::byte_t  data_o,
    output logic                  empty_o,
    output logic                  full_o,
    output uart_boot_pkg::count_t count_o
);
    import uart_boot_pkg::*;

    byte_t              mem [2**FIFO_AW];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic               do_push;
    logic               do_pop;

    assign do_push = push_i & ~full_o;       // Push on full is dropped
    assign do_pop  = pop_i & ~empty_o;       // Pop on empty is ignored
    assign empty_o = (count_o == '0);
    assign full_o  = count_o[FIFO_AW];       // Only set at 16
    assign data_o  = mem[rd_ptr];            // Head, valid the cycle after a push

    // Pointers and occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_o <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop) begin
                count_o <= count_o + 1'b1;
            end else if (do_pop && !do_push) begin
                count_o <= count_o - 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= data_i;
    end

endmodule

//--- verilog/uart_tx.sv
// Serial transmitter, 8N1 framing, fed from the transmit FIFO
module uart_tx (
    input  logic                 clk,
    input  logic                 rst,
    input  uart_boot_pkg::byte_t data_i,
    input  logic                 valid_i,
    output logic                 pop_o,
    output logic                 busy_o,
    output logic                 tx_o
);
    import uart_boot_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    logic [CNT_W-1:0] clk_cnt;                // Clocks inside current bit
    logic [3:0]       bit_cnt;                // 0 start, 1..8 data, 9 stop
    logic [9:0]       shreg;                  // Frame, LSB goes out first

    assign pop_o = valid_i & ~busy_o;         // Take a byte only when idle
    assign tx_o  = busy_o ? shreg[0] : 1'b1;  // Line idles high

    // Bit timing and frame sequencing
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_o  <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (pop_o) begin
            busy_o  <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (busy_o) begin
            if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
                clk_cnt <= '0;
                if (bit_cnt == 4'd9) busy_o <= 1'b0;   // Stop bit done
                else bit_cnt <= bit_cnt + 1'b1;
            end else begin
                clk_cnt <= clk_cnt + 1'b1;
            end
        end
    end

    // Shift register
    always_ff @(posedge clk) begin
        if (pop_o) begin
            shreg <= {1'b1, data_i, 1'b0};    // Stop, data, start
        end else if (busy_o && clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
            shreg <= {1'b1, shreg[9:1]};
        end
    end

endmodule

//--- verilog/uart_rx.sv
// Serial receiver with synchronizer, mid-bit sampling and stop bit check
module uart_rx (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rx_i,
    output logic                 push_o,
    output uart_boot_pkg::byte_t data_o
);
    import uart_boot_pkg::*;

    localparam int CNT_W = $clog2(CLKS_PER_BIT);

    typedef enum logic [1:0] {
        R_IDLE,
        R_START,
        R_DATA,
        R_STOP
    } rx_state_t;

    rx_state_t        state;
    logic [1:0]       sync;                    // Two-flop synchronizer
    logic             line_prev;               // For falling edge
    logic             line;
    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_cnt;
    logic             bit_end;

    assign line    = sync[1];
    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    // ------------------------------
    // Line synchronizer
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            sync      <= 2'b11;
            line_prev <= 1'b1;
        end else begin
            sync      <= {sync[0], rx_i};
            line_prev <= line;
        end
    end

    // ------------------------------
    // Frame FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= R_IDLE;
            clk_cnt <= '0;
            bit_cnt <= '0;
            push_o  <= 1'b0;
        end else begin
            push_o  <= 1'b0;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                R_IDLE: begin
                    clk_cnt <= '0;
                    if (line_prev && !line) state <= R_START;   // Start edge
                end
                R_START: begin
                    if (clk_cnt == CNT_W'(CLKS_PER_BIT / 2 - 1)) begin
                        clk_cnt <= '0;                           // Now at mid-bit
                        bit_cnt <= '0;
                        state   <= line ? R_IDLE : R_DATA;       // Glitch rejected
                    end
                end
                R_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        if (bit_cnt == 3'd7) state <= R_STOP;
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                R_STOP: begin
                    if (bit_end) begin
                        push_o <= line;       // Framing error drops the byte
                        state  <= R_IDLE;
                    end
                end
                default: state <= R_IDLE;
            endcase
        end
    end

    // Data bits at their centres, LSB first
    always_ff @(posedge clk) begin
        if (state == R_DATA && bit_end) data_o <= {line, data_o[7:1]};
    end

endmodule

//--- verilog/uart_regs.sv
// Wishbone slave registers, FIFO port steering, transmit and receive FIFOs with serial cores
module uart_regs (
    input  logic                 clk,
    input  logic                 rst,
    // Wishbone slave
    input  logic [2:0]           wb_adr_i,
    input  uart_boot_pkg::byte_t wb_dat_i,
    input  logic                 wb_we_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    output uart_boot_pkg::word_t wb_dat_o,
    output logic                 wb_ack_o,
    // Boot sequencer side
    input  logic                 core_rst_i,
    input  logic                 boot_tx_push_i,
    input  uart_boot_pkg::byte_t boot_tx_data_i,
    input  logic                 boot_rx_pop_i,
    output logic                 boot_rx_valid_o,
    output uart_boot_pkg::byte_t boot_rx_data_o,
    // Status and serial pins
    output logic                 tx_drained_o,
    output logic                 rx_ready_o,
    output logic                 tx_o,
    input  logic                 rx_i
);
    import uart_boot_pkg::*;

    logic   bus_req;
    logic   tx_push, tx_pop, tx_empty, tx_busy;
    logic   rx_push, rx_pop, rx_empty;
    byte_t  tx_data, tx_head, rx_byte, rx_head;
    count_t tx_count, rx_count;

    // Bus only served after boot, one access per request
    assign bus_req = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~core_rst_i;

    // ------------------------------
    // FIFO port owner
    // ------------------------------
    assign tx_push = core_rst_i ? boot_tx_push_i
                                : (bus_req & wb_we_i & (wb_adr_i == REG_BUFFER));
    assign tx_data = core_rst_i ? boot_tx_data_i : wb_dat_i;
    assign rx_pop  = core_rst_i ? boot_rx_pop_i
                                : (bus_req & ~wb_we_i & (wb_adr_i == REG_BUFFER));

    assign boot_rx_valid_o = ~rx_empty;
    assign boot_rx_data_o  = rx_head;
    assign rx_ready_o      = ~rx_empty;
    assign tx_drained_o    = tx_empty & ~tx_busy;   // FIFO and shifter both idle

    // One-cycle acknowledge
    always_ff @(posedge clk) begin
        if (rst) wb_ack_o <= 1'b0;
        else     wb_ack_o <= bus_req;
    end

    // Read data, captured with the pop
    always_ff @(posedge clk) begin
        if (bus_req && !wb_we_i) begin
            case (wb_adr_i)
                REG_BUFFER:   wb_dat_o <= rx_empty ? '0 : word_t'(rx_head);
                REG_TX_COUNT: wb_dat_o <= word_t'(tx_count);
                REG_RX_COUNT: wb_dat_o <= word_t'(rx_count);
                default:      wb_dat_o <= '0;
            endcase
        end
    end

    // ------------------------------
    // Transmit path
    // ------------------------------
    byte_fifo u_tx_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (tx_push),
        .data_i  (tx_data),
        .pop_i   (tx_pop),
        .data_o  (tx_head),
        .empty_o (tx_empty),
        .full_o  (),
        .count_o (tx_count)
    );

    uart_tx u_tx (
        .clk     (clk),
        .rst     (rst),
        .data_i  (tx_head),
        .valid_i (~tx_empty),
        .pop_o   (tx_pop),
        .busy_o  (tx_busy),
        .tx_o    (tx_o)
    );

    // Receive path
    uart_rx u_rx (
        .clk    (clk),
        .rst    (rst),
        .rx_i   (rx_i),
        .push_o (rx_push),
        .data_o (rx_byte)
    );

    byte_fifo u_rx_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (rx_push),
        .data_i  (rx_byte),
        .pop_i   (rx_pop),
        .data_o  (rx_head),
        .empty_o (rx_empty),
        .full_o  (),
        .count_o (rx_count)
    );

endmodule

//--- verilog/boot_sequencer.sv
// Boot protocol FSM, boot timeout counter and Wishbone memory write master
module boot_sequencer (
    input  logic                 clk,
    input  logic                 rst,
    // Byte ports
    output logic                 boot_tx_push_o,
    output uart_boot_pkg::byte_t boot_tx_data_o,
    output logic                 boot_rx_pop_o,
    input  logic                 boot_rx_valid_i,
    input  uart_boot_pkg::byte_t boot_rx_data_i,
    input  logic                 tx_drained_i,
    // Wishbone memory master
    output uart_boot_pkg::word_t mem_adr_o,
    output uart_boot_pkg::word_t mem_dat_o,
    output logic [3:0]           mem_sel_o,
    output logic                 mem_we_o,
    output logic                 mem_cyc_o,
    output logic                 mem_stb_o,
    input  logic                 mem_ack_i,
    output logic                 core_rst_o
);
    import uart_boot_pkg::*;

    localparam int TMO_W = $clog2(BOOT_TIMEOUT_CYCLES + 1);

    typedef enum logic [3:0] {
        S_IDLE, S_HDR, S_ACK_RX, S_SIZE, S_KCA, S_DATA, S_WRITE, S_FIN, S_DRAIN, S_DONE
    } state_t;

    state_t            state;
    logic [1:0]        idx;                   // Byte slot in token, size or word
    logic [SIZE_W-1:0] size;                  // Words minus one
    logic [SIZE_W-1:0] wcount;                // Words written so far
    logic [TMO_W-1:0]  tmo_cnt;
    logic              timeout;
    logic              rx_take;
    byte_t             ack_tok;               // A, C, K by slot
    word_t             addr;
    word_t             word;

    assign timeout = (tmo_cnt == TMO_W'(BOOT_TIMEOUT_CYCLES));
    assign rx_take = boot_rx_valid_i & (state inside {S_ACK_RX, S_SIZE, S_DATA});

    assign boot_rx_pop_o  = rx_take;
    assign boot_tx_push_o = state inside {S_HDR, S_KCA, S_FIN};   // One token byte per cycle

    // Memory request held for the whole write state
    assign mem_cyc_o = (state == S_WRITE);
    assign mem_stb_o = mem_cyc_o;
    assign mem_we_o  = mem_cyc_o;
    assign mem_sel_o = {4{mem_cyc_o}};
    assign mem_adr_o = addr;
    assign mem_dat_o = word;

    // ------------------------------
    // Token bytes
    // ------------------------------
    always_comb begin
        case (idx)
            2'd0:    ack_tok = TOK_A;
            2'd1:    ack_tok = TOK_C;
            default: ack_tok = TOK_K;
        endcase
    end

    always_comb begin
        boot_tx_data_o = ack_tok;             // Final ACK and default
        if (state == S_HDR) begin
            boot_tx_data_o = (idx == 2'd0) ? TOK_U : (idx == 2'd1) ? TOK_S : TOK_B;
        end else if (state == S_KCA) begin
            boot_tx_data_o = (idx == 2'd0) ? TOK_K : (idx == 2'd1) ? TOK_C : TOK_A;
        end
    end

    // Saturating timeout, counted from reset
    always_ff @(posedge clk) begin
        if (rst)           tmo_cnt <= '0;
        else if (!timeout) tmo_cnt <= tmo_cnt + 1'b1;
    end

    // ------------------------------
    // Protocol FSM
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            idx        <= '0;
            addr       <= '0;
            wcount     <= '0;
            core_rst_o <= 1'b1;
        end else if (timeout) begin
            state      <= S_DONE;             // Forced release in any state
            core_rst_o <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    idx   <= '0;
                    state <= S_HDR;
                end
                S_HDR, S_KCA, S_FIN: begin
                    idx <= idx + 1'b1;
                    if (idx == 2'd2) begin
                        idx <= '0;
                        if (state == S_HDR)      state <= S_ACK_RX;
                        else if (state == S_KCA) state <= S_DATA;
                        else                     state <= S_DRAIN;
                    end
                    addr   <= '0;             // New image starts at zero
                    wcount <= '0;
                end
                S_ACK_RX: begin
                    if (rx_take) begin
                        idx <= idx + 1'b1;
                        if (boot_rx_data_i != ack_tok) state <= S_IDLE;  // Resend header
                        else if (idx == 2'd2) begin
                            idx   <= '0;
                            state <= S_SIZE;
                        end
                    end
                end
                S_SIZE: begin
                    if (rx_take) begin
                        idx <= idx + 1'b1;
                        if (idx == 2'd2) begin
                            idx   <= '0;
                            state <= S_KCA;
                        end
                    end
                end
                S_DATA: begin
                    if (rx_take) begin
                        idx <= idx + 1'b1;            // Wraps after fourth byte
                        if (idx == 2'd3) state <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (mem_ack_i) begin
                        addr   <= addr + 32'd4;
                        wcount <= wcount + 1'b1;
                        state  <= (wcount == size) ? S_FIN : S_DATA;
                    end
                end
                S_DRAIN: begin
                    if (tx_drained_i) begin
                        core_rst_o <= 1'b0;       // Boot from memory
                        state      <= S_DONE;
                    end
                end
                S_DONE:  state <= S_DONE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Size and word assembly, little-endian
    always_ff @(posedge clk) begin
        if (rx_take && state == S_SIZE) begin
            case (idx)
                2'd0:    size[7:0]   <= boot_rx_data_i;
                2'd1:    size[15:8]  <= boot_rx_data_i;
                default: size[17:16] <= boot_rx_data_i[1:0];
            endcase
        end
        if (rx_take && state == S_DATA) word <= {boot_rx_data_i, word[31:8]};
    end

endmodule

//--- verilog/uart_bootloader.sv
// Top level of the UART boot loader, register block beside the boot sequencer
module uart_bootloader (
    input  logic                 clk,
    input  logic                 rst,
    // Wishbone slave, core access after boot
    input  logic [2:0]           wb_adr_i,
    input  uart_boot_pkg::byte_t wb_dat_i,
    input  logic                 wb_we_i,
    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    output uart_boot_pkg::word_t wb_dat_o,
    output logic                 wb_ack_o,
    // Wishbone memory master, program load
    output uart_boot_pkg::word_t mem_adr_o,
    output uart_boot_pkg::word_t mem_dat_o,
    output logic [3:0]           mem_sel_o,
    output logic                 mem_we_o,
    output logic                 mem_cyc_o,
    output logic                 mem_stb_o,
    input  logic                 mem_ack_i,
    // Serial pins and status
    input  logic                 rx_i,
    output logic                 tx_o,
    output logic                 rx_ready_o,
    output logic                 core_rst_o
);
    import uart_boot_pkg::*;

    logic  boot_tx_push;
    byte_t boot_tx_data;
    logic  boot_rx_pop;
    logic  boot_rx_valid;
    byte_t boot_rx_data;
    logic  tx_drained;

    // ------------------------------
    // UART and registers
    // ------------------------------
    uart_regs u_regs (
        .clk             (clk),
        .rst             (rst),
        .wb_adr_i        (wb_adr_i),
        .wb_dat_i        (wb_dat_i),
        .wb_we_i         (wb_we_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_stb_i        (wb_stb_i),
        .wb_dat_o        (wb_dat_o),
        .wb_ack_o        (wb_ack_o),
        .core_rst_i      (core_rst_o),    // Selects FIFO port owner
        .boot_tx_push_i  (boot_tx_push),
        .boot_tx_data_i  (boot_tx_data),
        .boot_rx_pop_i   (boot_rx_pop),
        .boot_rx_valid_o (boot_rx_valid),
        .boot_rx_data_o  (boot_rx_data),
        .tx_drained_o    (tx_drained),
        .rx_ready_o      (rx_ready_o),
        .tx_o            (tx_o),
        .rx_i            (rx_i)
    );

    // Boot protocol
    boot_sequencer u_boot (
        .clk             (clk),
        .rst             (rst),
        .boot_tx_push_o  (boot_tx_push),
        .boot_tx_data_o  (boot_tx_data),
        .boot_rx_pop_o   (boot_rx_pop),
        .boot_rx_valid_i (boot_rx_valid),
        .boot_rx_data_i  (boot_rx_data),
        .tx_drained_i    (tx_drained),
        .mem_adr_o       (mem_adr_o),
        .mem_dat_o       (mem_dat_o),
        .mem_sel_o       (mem_sel_o),
        .mem_we_o        (mem_we_o),
        .mem_cyc_o       (mem_cyc_o),
        .mem_stb_o       (mem_stb_o),
        .mem_ack_i       (mem_ack_i),
        .core_rst_o      (core_rst_o)
    );

endmodule

//--- verification/tb_clock.sv
// Testbench clock generator, 4 ns period
module tb_clock (
    output logic clk_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam time HALF_PERIOD = 2ns;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;   // Free running
    end

endmodule

//--- verification/uart_bootloader_assert.sv
// Concurrent checks on bus handshakes and core release bound to the top level
module uart_bootloader_assert (
    input logic                 clk,
    input logic                 rst,
    input logic                 wb_ack_o,
    input logic                 mem_cyc_o,
    input logic                 mem_stb_o,
    input uart_boot_pkg::word_t mem_adr_o,
    input uart_boot_pkg::word_t mem_dat_o,
    input logic                 mem_ack_i,
    input logic                 core_rst_o
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;                             // Failed property count

    // Slave acknowledge is a single-cycle pulse
    a_ack_pulse: assert property (@(posedge clk) disable iff (rst)
        wb_ack_o |=> !wb_ack_o)
        else begin
            fail_cnt++;
            $error("wb_ack_o high for two cycles");
        end

    // Memory request held steady until acknowledged
    a_mem_hold: assert property (@(posedge clk) disable iff (rst)
        (mem_cyc_o && mem_stb_o && !mem_ack_i) |=>
        (mem_cyc_o && mem_stb_o && $stable(mem_adr_o) && $stable(mem_dat_o)))
        else begin
            fail_cnt++;
            $error("memory request changed before mem_ack_i");
        end

    // Core stays out of reset once released
    a_core_stays: assert property (@(posedge clk) disable iff (rst)
        !core_rst_o |=> !core_rst_o)
        else begin
            fail_cnt++;
            $error("core_rst_o rose without reset");
        end

endmodule

bind uart_bootloader uart_bootloader_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .wb_ack_o   (wb_ack_o),
    .mem_cyc_o  (mem_cyc_o),
    .mem_stb_o  (mem_stb_o),
    .mem_adr_o  (mem_adr_o),
    .mem_dat_o  (mem_dat_o),
    .mem_ack_i  (mem_ack_i),
    .core_rst_o (core_rst_o)
);

//--- verification/uart_bootloader_tb.sv
// Table-driven testbench with serial driver and decoder, bus tasks and memory model
module uart_bootloader_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import uart_boot_pkg::*;

    localparam int  N_WORDS    = 4;
    localparam int  FRAME_CLKS = 10 * CLKS_PER_BIT;
    localparam int  BIT_NS     = CLKS_PER_BIT * 4;
    localparam int  WB_LIMIT   = 20;              // Cycles to wait for an acknowledge
    localparam byte_t TOK_BAD  = 8'h58;           // Wrong second token byte

    logic       clk, rst;
    logic [2:0] wb_adr_i;
    byte_t      wb_dat_i;
    logic       wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o;
    word_t      wb_dat_o, mem_adr_o, mem_dat_o;
    logic [3:0] mem_sel_o;
    logic       mem_we_o, mem_cyc_o, mem_stb_o, mem_ack_i;
    logic       rx_i, tx_o, rx_ready_o, core_rst_o;

    int    errors = 0;
    byte_t tx_q[$];                               // Bytes decoded from tx_o
    word_t mem_adr_q[$], mem_dat_q[$];
    logic [3:0] mem_sel_q[$];

    // ------------------------------
    // Stimulus tables
    // ------------------------------
    bit    tbl_exp[$];                            // 1 when the DUT sends the byte
    byte_t tbl_val[$];
    word_t boot_words [N_WORDS];
    byte_t slv_tx  [6] = '{8'h3c, 8'ha5, 8'h00, 8'hff, 8'h5a, 8'h81};
    int    slv_max [6] = '{1, 2, 3, 4, 5, 6};     // Upper bound of TX count
    byte_t slv_rx  [4] = '{8'h12, 8'hc3, 8'h7e, 8'h01};

    tb_clock u_clk (.clk_o(clk));

    uart_bootloader uut (
        .clk(clk), .rst(rst),
        .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_we_i(wb_we_i),
        .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
        .mem_adr_o(mem_adr_o), .mem_dat_o(mem_dat_o), .mem_sel_o(mem_sel_o),
        .mem_we_o(mem_we_o), .mem_cyc_o(mem_cyc_o), .mem_stb_o(mem_stb_o),
        .mem_ack_i(mem_ack_i),
        .rx_i(rx_i), .tx_o(tx_o), .rx_ready_o(rx_ready_o), .core_rst_o(core_rst_o)
    );

    // Memory model acks one cycle after each request
    always begin
        @(posedge clk);
        #1;
        if (!rst && mem_cyc_o && mem_stb_o && mem_we_o && !mem_ack_i) begin
            mem_adr_q.push_back(mem_adr_o);
            mem_dat_q.push_back(mem_dat_o);
            mem_sel_q.push_back(mem_sel_o);
            mem_ack_i = 1'b1;
        end else begin
            mem_ack_i = 1'b0;
        end
    end

    // Serial decoder samples each bit 1 ns past its middle
    always begin
        byte_t b;
        logic  start_ok;
        @(negedge tx_o);
        #(BIT_NS / 2 + 1);
        start_ok = (tx_o === 1'b0);
        assert (start_ok) else begin
            errors++;
            $display("error %0t: start bit on tx_o not held", $time);
        end
        if (start_ok) begin
            for (int i = 0; i < 8; i++) begin
                #(BIT_NS);
                b[i] = tx_o;                      // LSB first
            end
            #(BIT_NS);
            assert (tx_o === 1'b1) else begin
                errors++;
                $display("error %0t: stop bit low on tx_o", $time);
            end
            tx_q.push_back(b);
        end
    end

    // ------------------------------
    // Driver and bus tasks
    // ------------------------------
    task automatic apply_reset();
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1 rx_i = frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic expect_tx_byte(input byte_t exp);
        int    n;
        byte_t got;
        n = 0;
        while (tx_q.size() == 0 && n < 3 * FRAME_CLKS) begin
            @(posedge clk);
            n++;
        end
        if (tx_q.size() == 0) begin
            errors++;
            $display("no byte came out of the DUT while waiting for %h", exp);
        end else begin
            got = tx_q.pop_front();
            assert (got == exp) else begin
                errors++;
                $display("error %0t: tx byte %h, expected %h", $time, got, exp);
            end
        end
    endtask

    task automatic wb_access(input logic [2:0] adr, input logic we, input byte_t dat,
                             output word_t rdata);
        int n;
        n = 0;
        rdata = '0;
        @(posedge clk);
        #1;
        wb_adr_i = adr;
        wb_dat_i = dat;
        wb_we_i  = we;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!wb_ack_o && n < WB_LIMIT);
        if (!wb_ack_o) begin
            errors++;
            $display("bus request at address %0d was never acknowledged", adr);
        end
        rdata    = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic check_value(input word_t got, input word_t exp, input string what);
        assert (got == exp) else begin
            errors++;
            $display("error %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Waits for core_rst_o low and returns the cycles spent
    task automatic wait_release(input int limit, output int cycles);
        cycles = 0;
        while (core_rst_o && cycles < limit) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (core_rst_o) begin
            errors++;
            $display("core_rst_o was not released within %0d cycles", limit);
        end
    endtask

    // Serial stimulus table of the boot phase
    function automatic void add(input bit exp, input byte_t val);
        tbl_exp.push_back(exp);
        tbl_val.push_back(val);
    endfunction

    function automatic void build_boot_table();
        add(1, TOK_U);
        add(1, TOK_S);
        add(1, TOK_B);
        add(0, TOK_A);
        add(0, TOK_BAD);                                   // Wrong token
        add(1, TOK_U);
        add(1, TOK_S);
        add(1, TOK_B);
        add(0, TOK_A);
        add(0, TOK_C);
        add(0, TOK_K);
        add(0, byte_t'(N_WORDS - 1));                      // Size with low byte first
        add(0, byte_t'((N_WORDS - 1) >> 8));
        add(0, byte_t'((N_WORDS - 1) >> 16));
        add(1, TOK_K);
        add(1, TOK_C);
        add(1, TOK_A);
        for (int w = 0; w < N_WORDS; w++) begin
            for (int k = 0; k < 4; k++) add(0, boot_words[w][8*k +: 8]);
        end
        add(1, TOK_A);
        add(1, TOK_C);
        add(1, TOK_K);
    endfunction

    // Watchdog sized from the serial traffic plus twice the boot timeout
    initial begin
        wait (tbl_val.size() > 0);
        #((tbl_val.size() + 2 * $size(slv_tx) + $size(slv_rx) + 3) * FRAME_CLKS * 4
          + 2 * BOOT_TIMEOUT_CYCLES * 4);
        $display("watchdog expired at %0t", $time);
        $display("test failed");
        $finish;
    end

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        word_t rd;
        int    cyc;
        rst = 1'b1;
        rx_i = 1'b1;
        wb_adr_i = '0;
        wb_dat_i = '0;
        wb_we_i = 1'b0;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        mem_ack_i = 1'b0;
        void'($urandom(32'h193e));
        for (int w = 0; w < N_WORDS; w++) boot_words[w] = $urandom;
        build_boot_table();
        apply_reset();

        check_value(word_t'(core_rst_o), 32'd1, "core_rst_o after reset");
        check_value(word_t'(tx_o), 32'd1, "tx_o after reset");

        // Boot protocol from the table
        for (int i = 0; i < tbl_val.size(); i++) begin
            if (tbl_exp[i]) expect_tx_byte(tbl_val[i]);
            else            send_byte(tbl_val[i]);
        end
        wait_release(3 * FRAME_CLKS, cyc);
        check_value(mem_adr_q.size(), N_WORDS, "memory write count");
        for (int w = 0; w < N_WORDS && w < mem_adr_q.size(); w++) begin
            check_value(mem_adr_q[w], 4 * w, "memory address");
            check_value(word_t'(mem_sel_q[w]), 32'hf, "byte lane select");
            check_value(mem_dat_q[w], boot_words[w], "memory data");
        end

        // Slave mode transmit through the buffer register
        for (int i = 0; i < $size(slv_tx); i++) begin
            wb_access(REG_BUFFER, 1'b1, slv_tx[i], rd);
            wb_access(REG_TX_COUNT, 1'b0, '0, rd);
            assert (rd <= slv_max[i]) else begin
                errors++;
                $display("error %0t: TX count %0d above %0d", $time, rd, slv_max[i]);
            end
        end
        for (int i = 0; i < $size(slv_tx); i++) expect_tx_byte(slv_tx[i]);

        // Slave mode receive
        for (int i = 0; i < $size(slv_rx); i++) send_byte(slv_rx[i]);
        repeat (CLKS_PER_BIT) @(posedge clk);   // Last byte lands within one bit
        #1;
        check_value(word_t'(rx_ready_o), 32'd1, "rx_ready_o with data");
        wb_access(REG_RX_COUNT, 1'b0, '0, rd);
        check_value(rd, $size(slv_rx), "RX count");
        for (int i = 0; i < $size(slv_rx); i++) begin
            wb_access(REG_BUFFER, 1'b0, '0, rd);
            check_value(rd, word_t'(slv_rx[i]), "RX buffer read");
        end
        wb_access(REG_BUFFER, 1'b0, '0, rd);
        check_value(rd, 32'd0, "read of empty RX buffer");
        check_value(word_t'(rx_ready_o), 32'd0, "rx_ready_o when empty");

        // Forced release with a silent host
        apply_reset();
        wait_release(BOOT_TIMEOUT_CYCLES + FRAME_CLKS, cyc);
        assert (cyc >= BOOT_TIMEOUT_CYCLES) else begin
            errors++;
            $display("error %0t: core released after %0d cycles, before the timeout",
                     $time, cyc);
        end
        expect_tx_byte(TOK_U);
        expect_tx_byte(TOK_S);
        expect_tx_byte(TOK_B);
        wb_access(REG_RX_COUNT, 1'b0, '0, rd);
        check_value(rd, 32'd0, "RX count after forced release");

        errors += uut.u_assert.fail_cnt;           // Bound property failures
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
verilog/uart_boot_pkg.sv
verilog/byte_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/boot_sequencer.sv
verilog/uart_bootloader.sv
verification/tb_clock.sv
verification/uart_bootloader_assert.sv
verification/uart_bootloader_tb.sv

//--- Bender.yml
package:
  name: uart_bootloader

sources:
  - verilog/uart_boot_pkg.sv
  - verilog/byte_fifo.sv
  - verilog/uart_tx.sv
  - verilog/uart_rx.sv
  - verilog/uart_regs.sv
  - verilog/boot_sequencer.sv
  - verilog/uart_bootloader.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/uart_bootloader_assert.sv
      - verification/uart_bootloader_tb.sv
